/* source/video_params.svh */
// Video generator parameters
// Raster sizes, memory depths and the PROM load map

`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// Raster, in pixels and lines
`define H_ACTIVE    64
`define H_TOTAL     96
`define V_ACTIVE    32
`define V_TOTAL     40
`define HS_START    72
`define HS_LEN      8
`define VS_START    34
`define VS_LEN      2

// CPU side memories
`define VRAM_SIZE   8'd32
`define SCROLL_ADDR 8'd32
`define NUM_OBJ     4

// PROM load map
// Graphics: tile t row r at t*32 + r*4, byte k holds pixel 2k low, 2k+1 high
`define PAL_BASE    10'h000
`define PAL_SIZE    10'd32
`define GFX_BASE    10'h200
`define GFX_SIZE    10'd512

`endif

/* source/video_pkg.sv */
// Video generator types
// Pixel and palette index widths, object records and object FSM states

package video_pkg;

    // 4bpp pixel, 0 is transparent
    typedef logic [3:0] pxl_t;

    // Palette PROM index
    typedef logic [4:0] col_idx_t;

    // One object, as stored in object RAM
    typedef struct packed {
        logic [7:0] y;
        logic [7:0] x;
        logic [3:0] code;
        logic       hflip;
    } obj_rec_t;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_draw,
        st_done
    } obj_state_t;

endpackage

/* source/video_if.sv */
// Video generator interfaces
// Raster timing bundle and the object draw port into the line buffer

`timescale 1ns/1ps

interface video_timing_if;
    logic [6:0] hdump;
    logic [5:0] vdump;
    logic       lhbl;
    logic       lvbl;
    logic       hs;
    logic       vs;

    modport source (
        output hdump, vdump, lhbl, lvbl, hs, vs
    );

    modport sink (
        input  hdump, vdump, lhbl, lvbl, hs, vs
    );
endinterface

interface obj_draw_if import video_pkg::*; ();
    logic [5:0] waddr;
    pxl_t       wpxl;
    logic       we;

    // One pixel per strobe, into the hidden bank
    modport source (
        output waddr, wpxl, we
    );

    modport sink (
        input  waddr, wpxl, we
    );
endinterface

/* source/video_timer.sv */
// Raster timer
// Pixel and line counters with blanking and sync decode

`timescale 1ns/1ps
`include "video_params.svh"

module video_timer (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            pxl_cen,
    video_timing_if.source  vt
);

    logic [6:0] hcnt;
    logic [5:0] vcnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (hcnt == 7'(`H_TOTAL - 1)) begin
                hcnt <= '0;
                // Frame wrap
                vcnt <= (vcnt == 6'(`V_TOTAL - 1)) ? '0 : vcnt + 6'd1;
            end else begin
                hcnt <= hcnt + 7'd1;
            end
        end
    end

    assign vt.hdump = hcnt;
    assign vt.vdump = vcnt;
    assign vt.lhbl  = hcnt < 7'(`H_ACTIVE);
    assign vt.lvbl  = vcnt < 6'(`V_ACTIVE);
    assign vt.hs    = (hcnt >= 7'(`HS_START)) && (hcnt < 7'(`HS_START + `HS_LEN));
    assign vt.vs    = (vcnt >= 6'(`VS_START)) && (vcnt < 6'(`VS_START + `VS_LEN));

    a_hdump_range: assert property (@(posedge clk) disable iff (!arst_n)
        hcnt < 7'(`H_TOTAL));

endmodule

/* source/gfx_rom.sv */
// Graphics ROM
// Loaded from the PROM bus, shared by the tile layer and the object engine
// through two registered read ports

`timescale 1ns/1ps
`include "video_params.svh"

module gfx_rom (
    input  logic       clk,
    input  logic       pxl_cen,
    input  logic [9:0] prog_addr,
    input  logic [7:0] prog_data,
    input  logic       prog_we,
    input  logic [8:0] tile_addr,
    output logic [7:0] tile_data,
    input  logic [8:0] obj_addr,
    output logic [7:0] obj_data
);

    logic [7:0] mem [`GFX_SIZE];
    logic [9:0] gfx_off;

    assign gfx_off = prog_addr - `GFX_BASE;

    always_ff @(posedge clk) begin
        if (prog_we && (gfx_off < `GFX_SIZE)) begin
            mem[gfx_off[8:0]] <= prog_data;
        end
        // Reads land one pixel later
        if (pxl_cen) begin
            tile_data <= mem[tile_addr];
            obj_data  <= mem[obj_addr];
        end
    end

endmodule

/* source/tile_layer.sv */
// Scroll layer
// Tile-map RAM, horizontal scroll register and the pixel pipe
// Pixel for hdump h comes out two pixel clocks later

`timescale 1ns/1ps
`include "video_params.svh"

module tile_layer import video_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          pxl_cen,
    input  logic [7:0]    cpu_addr,
    input  logic [7:0]    cpu_dout,
    input  logic          cpu_we,
    input  logic          vram_cs,
    video_timing_if.sink  vt,
    output logic [8:0]    gfx_addr,
    input  logic [7:0]    gfx_data,
    output pxl_t          scr_pxl
);

    logic [3:0] vram [`VRAM_SIZE];
    logic [5:0] hscroll;
    logic [5:0] col;
    logic [3:0] code;
    logic       nib_hi;
    logic       cpu_wr;

    assign cpu_wr = pxl_cen && vram_cs && cpu_we;

    // Map is 8 columns by 4 rows of tiles
    always_ff @(posedge clk) begin
        if (cpu_wr && (cpu_addr < `VRAM_SIZE)) begin
            vram[cpu_addr[4:0]] <= cpu_dout[3:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hscroll <= '0;
        end else if (cpu_wr && (cpu_addr == `SCROLL_ADDR)) begin
            hscroll <= cpu_dout[5:0];
        end
    end

    // Scrolled column wraps at 64
    assign col  = vt.hdump[5:0] + hscroll;
    assign code = vram[{vt.vdump[4:3], col[5:3]}];

    // Four bytes per tile row, two pixels per byte
    assign gfx_addr = {code, vt.vdump[2:0], col[2:1]};

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            nib_hi  <= col[0];
            scr_pxl <= nib_hi ? gfx_data[7:4] : gfx_data[3:0];
        end
    end

endmodule

/* source/obj_scan_fsm.sv */
// Object engine
// Walks object RAM during horizontal blank and draws the next line's
// objects into the line buffer, one pixel per pixel clock

`timescale 1ns/1ps
`include "video_params.svh"

module obj_scan_fsm import video_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          pxl_cen,
    input  logic [7:0]    cpu_addr,
    input  logic [7:0]    cpu_dout,
    input  logic          cpu_we,
    input  logic          objram_cs,
    video_timing_if.sink  vt,
    output logic [8:0]    gfx_addr,
    input  logic [7:0]    gfx_data,
    obj_draw_if.source    draw
);

    localparam int IDX_W = $clog2(`NUM_OBJ);

    logic [7:0]       obj_ram [4 * `NUM_OBJ];
    obj_state_t       state;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] aidx;
    logic [2:0]       px;
    logic [2:0]       npx;
    logic             lhbl_last;
    logic             start;
    logic             emit;
    logic [5:0]       next_line;
    obj_rec_t         cur;
    obj_rec_t         arec;
    logic [8:0]       cur_dy;
    logic [8:0]       a_dy;
    logic             cur_hit;
    logic             a_hit;
    logic [2:0]       tcol;
    logic [2:0]       ccol;
    logic [8:0]       xpos;
    pxl_t             nib;

    function automatic obj_rec_t get_rec(input logic [IDX_W-1:0] i);
        obj_rec_t r;
        r.y     = obj_ram[{i, 2'd0}];
        r.x     = obj_ram[{i, 2'd1}];
        r.code  = obj_ram[{i, 2'd2}][3:0];
        r.hflip = obj_ram[{i, 2'd3}][0];
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (pxl_cen && objram_cs && cpu_we && (cpu_addr < 8'(4 * `NUM_OBJ))) begin
            obj_ram[cpu_addr[IDX_W+1:0]] <= cpu_dout;
        end
    end

    assign next_line = (vt.vdump == 6'(`V_TOTAL - 1)) ? 6'd0 : vt.vdump + 6'd1;
    assign start     = lhbl_last && !vt.lhbl;

    // On the last pixel the ROM is already pointed at the next object
    assign aidx = (state == st_draw && px == 3'd7) ? idx - IDX_W'(1) : idx;
    assign cur  = get_rec(idx);
    assign arec = get_rec(aidx);

    // Negative distances set bit 8 and miss
    assign cur_dy  = {3'd0, next_line} - {1'b0, cur.y};
    assign a_dy    = {3'd0, next_line} - {1'b0, arec.y};
    assign cur_hit = cur_dy < 9'd8;
    assign a_hit   = a_dy < 9'd8;

    // Prefetch the byte holding the next pixel
    assign npx      = px + 3'd1;
    assign tcol     = arec.hflip ? ~npx : npx;
    assign gfx_addr = {arec.code, a_dy[2:0], tcol[2:1]};

    assign ccol = cur.hflip ? ~px : px;
    assign nib  = ccol[0] ? gfx_data[7:4] : gfx_data[3:0];
    assign xpos = {1'b0, cur.x} + {6'd0, px};

    // First pixel goes out on the blank edge itself so that four full
    // objects fit in the 32 blank pixels
    assign emit = (state == st_draw) || (state == st_idle && start && cur_hit);

    assign draw.waddr = xpos[5:0];
    assign draw.wpxl  = nib;
    assign draw.we    = emit && (nib != 4'd0) && (xpos < 9'(`H_ACTIVE));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            idx       <= IDX_W'(`NUM_OBJ - 1);
            px        <= '0;
            lhbl_last <= 1'b1;
        end else if (pxl_cen) begin
            lhbl_last <= vt.lhbl;
            case (state)
                st_idle: begin
                    if (start) begin
                        if (cur_hit) begin
                            state <= st_draw;
                            px    <= 3'd1;
                        end else begin
                            state <= st_fetch;
                            idx   <= idx - IDX_W'(1);
                        end
                    end
                end
                st_fetch: begin
                    if (cur_hit) begin
                        state <= st_draw;
                    end else if (idx == '0) begin
                        state <= st_done;
                    end else begin
                        idx <= idx - IDX_W'(1);
                    end
                end
                st_draw: begin
                    px <= npx;
                    if (px == 3'd7) begin
                        if (idx == '0) begin
                            state <= st_done;
                        end else begin
                            idx <= aidx;
                            // Missing object costs one scan cycle
                            if (!a_hit) begin
                                state <= st_fetch;
                            end
                        end
                    end
                end
                default: begin
                    if (vt.lhbl) begin
                        state <= st_idle;
                        idx   <= IDX_W'(`NUM_OBJ - 1);
                        px    <= '0;
                    end
                end
            endcase
        end
    end

    a_done_by_active: assert property (@(posedge clk) disable iff (!arst_n)
        vt.lhbl |-> (state == st_idle || state == st_done));

endmodule

/* source/obj_line_buffer.sv */
// Object line buffer
// Two banks swapped at each line wrap, one drawn while the other shows
// Display reads take two pixel clocks and clear the entry behind them

`timescale 1ns/1ps
`include "video_params.svh"

module obj_line_buffer import video_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          pxl_cen,
    video_timing_if.sink  vt,
    obj_draw_if.sink      draw,
    output pxl_t          obj_pxl
);

    pxl_t bank [2][`H_ACTIVE];
    logic disp;
    pxl_t rd_pxl;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            disp <= 1'b0;
            // Start from empty banks
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < `H_ACTIVE; i++) begin
                    bank[b][i] <= '0;
                end
            end
        end else if (pxl_cen) begin
            if (vt.lhbl) begin
                bank[disp][vt.hdump[5:0]] <= '0;
            end
            if (draw.we) begin
                bank[~disp][draw.waddr] <= draw.wpxl;
            end
            if (vt.hdump == 7'(`H_TOTAL - 1)) begin
                disp <= ~disp;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rd_pxl  <= bank[disp][vt.hdump[5:0]];
            obj_pxl <= rd_pxl;
        end
    end

    // Drawing is confined to horizontal blank
    a_draw_in_blank: assert property (@(posedge clk) disable iff (!arst_n)
        draw.we |-> !vt.lhbl);

endmodule

/* source/colour_mixer.sv */
// Colour mixer
// Object over scroll priority, palette PROM lookup and output blanking
// Colour is registered three pixel clocks after hdump

`timescale 1ns/1ps
`include "video_params.svh"

module colour_mixer import video_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          pxl_cen,
    video_timing_if.sink  vt,
    input  pxl_t          scr_pxl,
    input  pxl_t          obj_pxl,
    input  logic [9:0]    prog_addr,
    input  logic [7:0]    prog_data,
    input  logic          prog_we,
    output logic [3:0]    red,
    output logic [3:0]    green,
    output logic [3:0]    blue,
    output logic          lhbl_dly,
    output logic          lvbl_dly
);

    logic [7:0] pal [`PAL_SIZE];
    logic [9:0] pal_off;
    col_idx_t   col_idx;
    logic [7:0] pal_byte;
    logic [2:0] hbl_sr;
    logic [2:0] vbl_sr;

    assign pal_off = prog_addr - `PAL_BASE;

    always_ff @(posedge clk) begin
        if (prog_we && (pal_off < `PAL_SIZE)) begin
            pal[pal_off[4:0]] <= prog_data;
        end
    end

    // Upper half of the palette belongs to objects
    assign col_idx  = (obj_pxl != 4'd0) ? {1'b1, obj_pxl} : {1'b0, scr_pxl};
    assign pal_byte = pal[col_idx];

    // Palette byte is BBGGGRRR
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hbl_sr <= '1;
            vbl_sr <= '1;
            red    <= '0;
            green  <= '0;
            blue   <= '0;
        end else if (pxl_cen) begin
            hbl_sr <= {hbl_sr[1:0], vt.lhbl};
            vbl_sr <= {vbl_sr[1:0], vt.lvbl};
            if (hbl_sr[1] && vbl_sr[1]) begin
                red   <= {pal_byte[2:0], pal_byte[2]};
                green <= {pal_byte[5:3], pal_byte[5]};
                blue  <= {pal_byte[7:6], {2{pal_byte[7]}}};
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

    assign lhbl_dly = hbl_sr[2];
    assign lvbl_dly = vbl_sr[2];

endmodule

/* source/video_top.sv */
// Tile and sprite video generator
// Raster timer, scroll layer, object engine with line buffer and
// palette mixer, fed by a CPU bus and a PROM load bus

`timescale 1ns/1ps

module video_top import video_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       pxl_cen,
    // CPU bus
    input  logic [7:0] cpu_addr,
    input  logic [7:0] cpu_dout,
    input  logic       cpu_we,
    input  logic       vram_cs,
    input  logic       objram_cs,
    // PROM load
    input  logic [9:0] prog_addr,
    input  logic [7:0] prog_data,
    input  logic       prog_we,
    // Video out
    output logic       hs,
    output logic       vs,
    output logic       lhbl_dly,
    output logic       lvbl_dly,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);

    logic [8:0] scr_gfx_addr;
    logic [7:0] scr_gfx_data;
    logic [8:0] obj_gfx_addr;
    logic [7:0] obj_gfx_data;
    pxl_t       scr_pxl;
    pxl_t       obj_pxl;

    video_timing_if vt ();
    obj_draw_if     draw ();

    assign hs = vt.hs;
    assign vs = vt.vs;

    video_timer u_timer (
        .clk     ( clk      ),
        .arst_n  ( arst_n   ),
        .pxl_cen ( pxl_cen  ),
        .vt      ( vt       )
    );

    gfx_rom u_gfx (
        .clk       ( clk          ),
        .pxl_cen   ( pxl_cen      ),
        .prog_addr ( prog_addr    ),
        .prog_data ( prog_data    ),
        .prog_we   ( prog_we      ),
        .tile_addr ( scr_gfx_addr ),
        .tile_data ( scr_gfx_data ),
        .obj_addr  ( obj_gfx_addr ),
        .obj_data  ( obj_gfx_data )
    );

    tile_layer u_scroll (
        .clk      ( clk          ),
        .arst_n   ( arst_n       ),
        .pxl_cen  ( pxl_cen      ),
        .cpu_addr ( cpu_addr     ),
        .cpu_dout ( cpu_dout     ),
        .cpu_we   ( cpu_we       ),
        .vram_cs  ( vram_cs      ),
        .vt       ( vt           ),
        .gfx_addr ( scr_gfx_addr ),
        .gfx_data ( scr_gfx_data ),
        .scr_pxl  ( scr_pxl      )
    );

    obj_scan_fsm u_obj (
        .clk       ( clk          ),
        .arst_n    ( arst_n       ),
        .pxl_cen   ( pxl_cen      ),
        .cpu_addr  ( cpu_addr     ),
        .cpu_dout  ( cpu_dout     ),
        .cpu_we    ( cpu_we       ),
        .objram_cs ( objram_cs    ),
        .vt        ( vt           ),
        .gfx_addr  ( obj_gfx_addr ),
        .gfx_data  ( obj_gfx_data ),
        .draw      ( draw         )
    );

    obj_line_buffer u_linebuf (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .pxl_cen ( pxl_cen ),
        .vt      ( vt      ),
        .draw    ( draw    ),
        .obj_pxl ( obj_pxl )
    );

    colour_mixer u_colmix (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .pxl_cen   ( pxl_cen   ),
        .vt        ( vt        ),
        .scr_pxl   ( scr_pxl   ),
        .obj_pxl   ( obj_pxl   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  )
    );

endmodule

/* dv/video_tb.sv */
// Testbench for the tile and sprite video generator
// Loads the PROMs, programs the CPU-side memories and compares captured
// frames against a pixel model built from the raster and colour rules

`timescale 1ns/1ps
`include "video_params.svh"

module video_tb;

    localparam int FRAME_CYC = 2 * `H_TOTAL * `V_TOTAL;
    // PROM load, object and map writes, then six frames of tests
    localparam int LOAD_CYC    = 2 * (`PAL_SIZE + `GFX_SIZE) + 3 * 80;
    localparam int TIMEOUT_CYC = 6 * FRAME_CYC + LOAD_CYC;
    localparam int NPIX        = `H_ACTIVE * `V_ACTIVE;

    logic       clk;
    logic       arst_n;
    logic       pxl_cen;
    logic [7:0] cpu_addr;
    logic [7:0] cpu_dout;
    logic       cpu_we;
    logic       vram_cs;
    logic       objram_cs;
    logic [9:0] prog_addr;
    logic [7:0] prog_data;
    logic       prog_we;
    logic       hs;
    logic       vs;
    logic       lhbl_dly;
    logic       lvbl_dly;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    // Model state mirrors everything written into the DUT
    logic [7:0]  pal_img [32];
    logic [7:0]  gfx_img [512];
    logic [3:0]  map_img [32];
    logic [11:0] cap [NPIX];
    int          hscroll_m;
    int          oy [`NUM_OBJ];
    int          ox [`NUM_OBJ];
    int          ocode [`NUM_OBJ];
    logic        oflip [`NUM_OBJ];
    int          mismatches;
    int          cycles;
    integer      seed;

    video_top dut0 (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .pxl_cen   ( pxl_cen   ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_we    ( cpu_we    ),
        .vram_cs   ( vram_cs   ),
        .objram_cs ( objram_cs ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Pixel clock enable on every other cycle
    always @(posedge clk) begin
        #2;
        pxl_cen = ~pxl_cen;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYC) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYC);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [3:0] gfx_pixel(input int code, input int row, input int col);
        logic [7:0] b;
        b = gfx_img[code * 32 + row * 4 + col / 2];
        return (col % 2 == 1) ? b[7:4] : b[3:0];
    endfunction

    // Red in bits 2:0, green in 5:3, blue in 7:6, top bit repeated
    function automatic logic [11:0] widen(input logic [7:0] b);
        return {b[2:0], b[2], b[5:3], b[5], b[7:6], b[7], b[7]};
    endfunction

    function automatic logic [11:0] expected_rgb(input int h, input int v);
        logic [3:0] sp;
        logic [3:0] op;
        logic [3:0] p;
        int         c;
        int         col;
        c  = (h + hscroll_m) % 64;
        sp = gfx_pixel(map_img[(v / 8) * 8 + c / 8], v % 8, c % 8);
        op = 4'd0;
        // Lowest index last so that it wins
        for (int i = `NUM_OBJ - 1; i >= 0; i--) begin
            if (v >= oy[i] && v < oy[i] + 8 && h >= ox[i] && h < ox[i] + 8) begin
                col = h - ox[i];
                if (oflip[i]) col = 7 - col;
                p = gfx_pixel(ocode[i], v - oy[i], col);
                if (p != 4'd0) op = p;
            end
        end
        return widen(pal_img[(op != 4'd0) ? {1'b1, op} : {1'b0, sp}]);
    endfunction

    task automatic prog_write(input logic [9:0] addr, input logic [7:0] data);
        @(posedge clk);
        #2;
        prog_addr = addr;
        prog_data = data;
        prog_we   = 1'b1;
        @(posedge clk);
        #2;
        prog_we = 1'b0;
    endtask

    // Held over two edges so exactly one of them has pxl_cen high
    task automatic bus_write(input logic obj_sel, input logic [7:0] addr,
                             input logic [7:0] data);
        @(posedge clk);
        #2;
        cpu_addr  = addr;
        cpu_dout  = data;
        cpu_we    = 1'b1;
        vram_cs   = ~obj_sel;
        objram_cs = obj_sel;
        repeat (2) @(posedge clk);
        #2;
        cpu_we    = 1'b0;
        vram_cs   = 1'b0;
        objram_cs = 1'b0;
    endtask

    task automatic set_object(input int i, input int y, input int x, input int code,
                              input logic flip);
        oy[i]    = y;
        ox[i]    = x;
        ocode[i] = code;
        oflip[i] = flip;
        bus_write(1'b1, 8'(i * 4), 8'(y));
        bus_write(1'b1, 8'(i * 4 + 1), 8'(x));
        bus_write(1'b1, 8'(i * 4 + 2), 8'(code));
        bus_write(1'b1, 8'(i * 4 + 3), {7'd0, flip});
    endtask

    task automatic set_scroll(input int s);
        hscroll_m = s;
        bus_write(1'b0, `SCROLL_ADDR, 8'(s));
    endtask

    task automatic load_proms();
        for (int i = 0; i < 32; i++) begin
            pal_img[i] = 8'(i * 37 + 91);
            prog_write(`PAL_BASE + 10'(i), pal_img[i]);
        end
        for (int a = 0; a < 512; a++) begin
            gfx_img[a] = {4'(a) ^ 4'(a >> 5), 4'(a >> 5) + 4'(a >> 1)};
            prog_write(`GFX_BASE + 10'(a), gfx_img[a]);
        end
    endtask

    // One sample per pixel, at a falling edge just before an enabled rising edge
    task automatic next_pixel();
        @(negedge clk);
        while (!pxl_cen) @(negedge clk);
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        assert (got == exp) else begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic capture_frame();
        int n;
        int shown;
        n = 0;
        shown = 0;
        next_pixel();
        while (lvbl_dly) next_pixel();
        while (n < NPIX) begin
            next_pixel();
            if (lhbl_dly && lvbl_dly) begin
                cap[n] = {red, green, blue};
                n++;
            end else begin
                // Black outside the active area
                assert ({red, green, blue} == 12'h000) else begin
                    mismatches++;
                    shown++;
                    if (shown <= 8) begin
                        $display("Mismatch at %0t: rgb in blanking got %h, expected %h",
                                 $time, {red, green, blue}, 12'h000);
                    end
                end
            end
        end
    endtask

    task automatic check_frame(input string what);
        logic [11:0] exp;
        int          shown;
        shown = 0;
        for (int v = 0; v < `V_ACTIVE; v++) begin
            for (int h = 0; h < `H_ACTIVE; h++) begin
                exp = expected_rgb(h, v);
                assert (cap[v * `H_ACTIVE + h] == exp) else begin
                    mismatches++;
                    shown++;
                    if (shown <= 8) begin
                        $display("Mismatch at %0t: rgb at (%0d,%0d) of %s frame got %h, expected %h",
                                 $time, h, v, what, cap[v * `H_ACTIVE + h], exp);
                    end
                end
            end
        end
    endtask

    task automatic check_raster();
        int   pix;
        int   lines;
        int   hs_hi;
        int   vs_hi;
        int   act;
        int   last_hs;
        logic hs_q;
        logic vs_q;
        next_pixel();
        vs_q = vs;
        next_pixel();
        while (!(vs && !vs_q)) begin
            vs_q = vs;
            next_pixel();
        end
        pix = 0;
        lines = 0;
        hs_hi = 0;
        vs_hi = 0;
        act = 0;
        last_hs = -1;
        hs_q = hs;
        vs_q = 1'b0;
        while (!(vs && !vs_q) || pix == 0) begin
            if (hs && !hs_q) begin
                lines++;
                if (last_hs >= 0) check_count("hs period", pix - last_hs, `H_TOTAL);
                last_hs = pix;
            end
            if (hs) hs_hi++;
            if (vs) vs_hi++;
            if (lhbl_dly && lvbl_dly) act++;
            hs_q = hs;
            vs_q = vs;
            pix++;
            next_pixel();
        end
        check_count("pixels per frame", pix, `H_TOTAL * `V_TOTAL);
        check_count("hs pulses per frame", lines, `V_TOTAL);
        check_count("hs high pixels", hs_hi, `HS_LEN * `V_TOTAL);
        check_count("vs high pixels", vs_hi, `VS_LEN * `H_TOTAL);
        check_count("active pixels", act, NPIX);
    endtask

    task automatic check_tile_map();
        for (int i = 0; i < 32; i++) begin
            map_img[i] = 4'($random(seed));
            bus_write(1'b0, 8'(i), {4'd0, map_img[i]});
        end
        set_scroll(0);
        capture_frame();
        check_frame("tile map");
    endtask

    task automatic check_scroll();
        set_scroll(5);
        capture_frame();
        check_frame("scroll 5");
        set_scroll(63);
        capture_frame();
        check_frame("scroll 63");
    endtask

    // Plain, clipped at the right edge, mirrored, and an overlapping pair
    task automatic check_objects();
        set_object(0, 18, 10, 5, 1'b0);
        set_object(1, 4, 60, 3, 1'b0);
        set_object(2, 21, 13, 9, 1'b0);
        set_object(3, 10, 28, 3, 1'b1);
        set_scroll(0);
        capture_frame();
        check_frame("objects");
    endtask

    task automatic check_priority();
        logic [3:0]  p0;
        logic [11:0] exp;
        for (int v = oy[2]; v < oy[0] + 8; v++) begin
            for (int h = ox[2]; h < ox[0] + 8; h++) begin
                p0 = gfx_pixel(ocode[0], v - oy[0], h - ox[0]);
                if (p0 != 4'd0) begin
                    exp = widen(pal_img[{1'b1, p0}]);
                    assert (cap[v * `H_ACTIVE + h] == exp) else begin
                        mismatches++;
                        $display("Mismatch at %0t: rgb at (%0d,%0d) in overlap got %h, expected %h",
                                 $time, h, v, cap[v * `H_ACTIVE + h], exp);
                    end
                end
            end
        end
    endtask

    initial begin
        seed       = 32'he8f4b774;
        mismatches = 0;
        hscroll_m  = 0;
        arst_n     = 1'b0;
        pxl_cen    = 1'b0;
        cpu_addr   = '0;
        cpu_dout   = '0;
        cpu_we     = 1'b0;
        vram_cs    = 1'b0;
        objram_cs  = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        prog_we    = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;

        load_proms();
        // Park all objects below the screen
        for (int i = 0; i < `NUM_OBJ; i++) begin
            set_object(i, 200, 0, 0, 1'b0);
        end
        check_raster();
        check_tile_map();
        check_scroll();
        check_objects();
        check_priority();

        $display("Errors: %0d mismatches", mismatches);
        if (mismatches == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+source
source/video_pkg.sv
source/video_if.sv
source/video_timer.sv
source/gfx_rom.sv
source/tile_layer.sv
source/obj_scan_fsm.sv
source/obj_line_buffer.sv
source/colour_mixer.sv
source/video_top.sv
dv/video_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the video generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module video_tb -Mdir obj_dir

./obj_dir/Vvideo_tb > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
